// ==== compile.f ====
rtl/image_pkg.sv
rtl/op_pkg.sv
rtl/sram_bank.sv
rtl/image_mem.sv
rtl/view_regs.sv
rtl/display_streamer.sv
rtl/op_ctrl.sv
rtl/image_core.sv
verification/tb_clk_gen.sv
verification/image_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the image_core testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module image_core_tb -f compile.f \
    -o image_core_sim &&
./obj_dir/image_core_sim | tee /dev/stderr | grep -q "STATUS: PASS" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// ==== verification/image_core_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module image_core_tb;

    localparam int     NPIX        = 2048;
    localparam int     ORG_LIMIT   = 6;         // 2x2 window inside 8x8
    localparam int     WAIT_MAX    = 400;       // cycles allowed per handshake
    localparam longint WATCHDOG_NS = 64'd20 * NPIX * 10 + 64'd20_000;

    logic               clk;
    logic               rst_n;
    logic               op_valid;
    logic [3:0]         op_mode;
    logic               in_valid;
    logic [7:0]         in_data;
    logic               op_ready;
    logic               in_ready;
    logic               out_valid;
    logic signed [13:0] out_data;

    logic [7:0] img [NPIX];                     // reference image indexed c*64 + y*8 + x
    int         ox;                             // window origin model
    int         oy;
    int         chans;                          // displayed channels 8/16/32
    int         err_cnt;                        // wrong values
    int         fail_cnt;                       // missing handshakes

    tb_clk_gen u_clk_gen (
        .o_clk  (clk),
        .o_rst_n(rst_n)
    );

    image_core #(
        .NUM_BANKS(4)
    ) i_image_core (
        .i_clk      (clk),
        .i_rst_n    (rst_n),
        .i_op_valid (op_valid),
        .i_op_mode  (op_mode),
        .i_in_valid (in_valid),
        .i_in_data  (in_data),
        .o_op_ready (op_ready),
        .o_in_ready (in_ready),
        .o_out_valid(out_valid),
        .o_out_data (out_data)
    );

    // ------------------------------------------------------------------
    // host side helpers that drive on falling edges
    // ------------------------------------------------------------------
    task automatic send_op(input logic [3:0] code);
        @(negedge clk);
        op_valid = 1'b1;                        // one-cycle strobe
        op_mode  = code;
        @(negedge clk);
        op_valid = 1'b0;
    endtask

    task automatic wait_op_ready(input string what);
        int n;
        n = 0;
        while (!op_ready && n < WAIT_MAX) begin
            @(negedge clk);
            n++;
        end
        if (!op_ready) begin
            $display("no op-ready pulse after %s within %0d cycles", what, WAIT_MAX);
            fail_cnt++;
        end
    endtask

    // shift or scale with a saturating model update
    task automatic view_op(input op_pkg::opcode_t code);
        send_op(code);
        case (code)
            op_pkg::OP_ORG_R:   if (ox < ORG_LIMIT) ox++;
            op_pkg::OP_ORG_L:   if (ox > 0) ox--;
            op_pkg::OP_ORG_D:   if (oy < ORG_LIMIT) oy++;
            op_pkg::OP_ORG_U:   if (oy > 0) oy--;
            op_pkg::OP_SCALE_D: if (chans > 8) chans = chans / 2;
            op_pkg::OP_SCALE_U: if (chans < 32) chans = chans * 2;
            default: ;
        endcase
        wait_op_ready("view command");
    endtask

    // expected stream has channel outer and tile (x,y) (x+1,y) (x,y+1) (x+1,y+1) inner
    task automatic display_check(input int exp_words, input string what);
        logic [7:0]         exp_q [$];
        logic signed [13:0] exp_word;
        int                 n;
        int                 got;
        int                 x;
        int                 y;
        for (int c = 0; c < chans; c++) begin
            for (int t = 0; t < 4; t++) begin
                x = ox + (t % 2);
                y = oy + (t / 2);
                exp_q.push_back(img[c * 64 + y * 8 + x]);
            end
        end
        send_op(op_pkg::OP_DISPLAY);
        n   = 0;
        got = 0;
        while (!op_ready && n < WAIT_MAX) begin
            if (out_valid) begin
                if (got < exp_q.size()) begin
                    exp_word = {6'd0, exp_q[got]};      // zero-extended pixel
                    if (out_data !== exp_word) begin
                        $display("[ERROR] %0t ns: %s word %0d is %0d, expected %0d",
                                 $time, what, got, out_data, exp_word);
                        err_cnt++;
                    end
                end
                got++;
            end
            @(negedge clk);
            n++;
        end
        if (!op_ready) begin
            $display("display of %s never returned op-ready", what);
            fail_cnt++;
        end
        if (got != exp_words) begin
            $display("[ERROR] %0t ns: %s gave %0d words, expected %0d",
                     $time, what, got, exp_words);
            err_cnt++;
        end
    endtask

    // ------------------------------------------------------------------
    // tests
    // ------------------------------------------------------------------
    task automatic reset_test();
        int pulses;
        pulses = 0;
        @(negedge clk);
        while (!rst_n) begin
            if (op_ready !== 1'b0 || in_ready !== 1'b0 || out_valid !== 1'b0
                || out_data !== '0) begin
                $display("[ERROR] %0t ns: output active during reset", $time);
                err_cnt++;
            end
            @(negedge clk);
        end
        repeat (20) begin                       // window after release
            if (op_ready === 1'b1) pulses++;
            if (in_ready !== 1'b0 || out_valid !== 1'b0) begin
                $display("[ERROR] %0t ns: in-ready or out-valid after reset", $time);
                err_cnt++;
            end
            @(negedge clk);
        end
        if (pulses != 1) begin
            $display("[ERROR] %0t ns: %0d op-ready pulses after reset, expected 1",
                     $time, pulses);
            err_cnt++;
        end
    endtask

    task automatic load_display_test();
        int n;
        int gap;
        for (int i = 0; i < NPIX; i++) img[i] = 8'($urandom);
        send_op(op_pkg::OP_LOAD);
        n = 0;
        while (!in_ready && n < WAIT_MAX) begin
            @(negedge clk);
            n++;
        end
        if (!in_ready) begin
            $display("in-ready never rose after the load opcode");
            fail_cnt++;
        end else begin
            for (int i = 0; i < NPIX; i++) begin
                if ($urandom % 4 == 0) begin    // idle gap of 1..3 cycles
                    gap      = 1 + int'($urandom % 3);
                    in_valid = 1'b0;
                    repeat (gap) @(negedge clk);
                end
                if (!in_ready) begin
                    $display("[ERROR] %0t ns: in-ready low at pixel %0d", $time, i);
                    err_cnt++;
                end
                in_valid = 1'b1;
                in_data  = img[i];              // raster order channel then y then x
                @(negedge clk);
            end
            in_valid = 1'b0;
            wait_op_ready("load");
        end
        display_check(128, "default window");
    endtask

    task automatic origin_test();
        repeat (8) view_op(op_pkg::OP_ORG_R);   // saturates at 6
        repeat (3) view_op(op_pkg::OP_ORG_D);
        repeat (2) view_op(op_pkg::OP_ORG_L);   // ends at (4,3)
        display_check(128, "window at (4,3)");
    endtask

    task automatic depth_test();
        repeat (3) view_op(op_pkg::OP_SCALE_D); // last one saturates
        display_check(32, "depth 8");
        view_op(op_pkg::OP_SCALE_U);
        display_check(64, "depth 16");
        repeat (3) view_op(op_pkg::OP_SCALE_U);
        display_check(128, "depth 32 saturated");
    endtask

    task automatic ignored_op_test();
        for (int code = 8; code <= 10; code++) begin
            send_op(4'(code));
            repeat (20) begin                   // must stay quiet
                if (op_ready || out_valid) begin
                    $display("[ERROR] %0t ns: opcode %0d was not ignored", $time, code);
                    err_cnt++;
                end
                @(negedge clk);
            end
        end
        display_check(128, "display after ignored opcodes");
    endtask

    // ------------------------------------------------------------------
    // sequence and verdict
    // ------------------------------------------------------------------
    initial begin
        void'($urandom(94));
        op_valid = 1'b0;
        op_mode  = 4'd0;
        in_valid = 1'b0;
        in_data  = 8'd0;
        err_cnt  = 0;
        fail_cnt = 0;
        ox       = 0;
        oy       = 0;
        chans    = 32;                          // reset depth
        reset_test();
        load_display_test();
        origin_test();
        depth_test();
        ignored_op_test();
        $display("errors: %0d wrong values, %0d missing handshakes", err_cnt, fail_cnt);
        if (err_cnt == 0 && fail_cnt == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // load dominates and takes well under 20 cycles per pixel
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/tb_clk_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD_NS  = 10,
    parameter int RST_CYCLES = 16
) (
    output logic o_clk,
    output logic o_rst_n
);

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2) o_clk = ~o_clk;
    end

    // short high blip first, so the async resets see a real falling edge
    initial begin
        o_rst_n = 1'b1;
        #1;
        o_rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge o_clk);
        @(negedge o_clk);
        o_rst_n = 1'b1;                    // release away from the rising edge
    end

endmodule

`default_nettype wire

// ==== rtl/image_core.sv ====
`timescale 1ns/1ns
`default_nettype none

module image_core #(
    parameter int NUM_BANKS = 4                   // power of two, 1..32
) (
    input  logic                               i_clk,
    input  logic                               i_rst_n,
    input  logic                               i_op_valid,
    input  logic [op_pkg::OP_W-1:0]            i_op_mode,
    input  logic                               i_in_valid,
    input  logic [image_pkg::PIX_W-1:0]        i_in_data,
    output logic                               o_op_ready,
    output logic                               o_in_ready,
    output logic                               o_out_valid,
    output logic signed [image_pkg::OUT_W-1:0] o_out_data
);

    // load path
    logic                            wr_en;
    logic [image_pkg::PIX_IDX_W-1:0] wr_idx;
    logic [image_pkg::PIX_W-1:0]     wr_data;

    // view state
    logic                            view_cmd_valid;
    op_pkg::opcode_t                 view_cmd;
    logic [image_pkg::COORD_W-1:0]   origin_x;
    logic [image_pkg::COORD_W-1:0]   origin_y;
    image_pkg::depth_t               depth;

    // display path
    logic                            disp_start;
    logic                            disp_done;
    logic                            rd_en;
    logic [image_pkg::COORD_W-1:0]   rd_x;
    logic [image_pkg::COORD_W-1:0]   rd_y;
    logic [image_pkg::CHAN_W-1:0]    rd_c;
    logic [image_pkg::PIX_W-1:0]     rd_data;

    op_ctrl u_op_ctrl (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_op_valid      (i_op_valid),
        .i_op_mode       (i_op_mode),
        .i_in_valid      (i_in_valid),
        .i_in_data       (i_in_data),
        .i_disp_done     (disp_done),
        .o_op_ready      (o_op_ready),
        .o_in_ready      (o_in_ready),
        .o_wr_en         (wr_en),
        .o_wr_idx        (wr_idx),
        .o_wr_data       (wr_data),
        .o_view_cmd_valid(view_cmd_valid),
        .o_view_cmd      (view_cmd),
        .o_disp_start    (disp_start)
    );

    view_regs u_view_regs (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_cmd_valid(view_cmd_valid),
        .i_cmd      (view_cmd),
        .o_origin_x (origin_x),
        .o_origin_y (origin_y),
        .o_depth    (depth)
    );

    display_streamer u_display_streamer (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_start    (disp_start),
        .i_origin_x (origin_x),
        .i_origin_y (origin_y),
        .i_depth    (depth),
        .i_rd_data  (rd_data),
        .o_rd_en    (rd_en),
        .o_rd_x     (rd_x),
        .o_rd_y     (rd_y),
        .o_rd_c     (rd_c),
        .o_out_valid(o_out_valid),
        .o_out_data (o_out_data),
        .o_disp_done(disp_done)
    );

    image_mem #(
        .NUM_BANKS(NUM_BANKS)
    ) u_image_mem (
        .i_clk    (i_clk),
        .i_wr_en  (wr_en),
        .i_wr_idx (wr_idx),
        .i_wr_data(wr_data),
        .i_rd_en  (rd_en),
        .i_rd_x   (rd_x),
        .i_rd_y   (rd_y),
        .i_rd_c   (rd_c),
        .o_rd_data(rd_data)
    );

endmodule

`default_nettype wire

// ==== rtl/op_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module op_ctrl (
    input  logic                            i_clk,
    input  logic                            i_rst_n,
    input  logic                            i_op_valid,
    input  logic [op_pkg::OP_W-1:0]         i_op_mode,
    input  logic                            i_in_valid,
    input  logic [image_pkg::PIX_W-1:0]     i_in_data,
    input  logic                            i_disp_done,
    output logic                            o_op_ready,
    output logic                            o_in_ready,
    output logic                            o_wr_en,
    output logic [image_pkg::PIX_IDX_W-1:0] o_wr_idx,
    output logic [image_pkg::PIX_W-1:0]     o_wr_data,
    output logic                            o_view_cmd_valid,
    output op_pkg::opcode_t                 o_view_cmd,
    output logic                            o_disp_start
);

    typedef enum logic [2:0] {
        S_RESET,
        S_START,
        S_READY,                                  // op-ready pulse
        S_WAIT,
        S_LOAD,
        S_VIEW,                                   // shift or scale
        S_DISP
    } state_t;

    state_t                          state;
    state_t                          state_next;
    logic                            op_valid_r;
    logic [op_pkg::OP_W-1:0]         op_mode_r;
    logic                            in_valid_r;
    logic [image_pkg::PIX_W-1:0]     in_data_r;
    logic [image_pkg::PIX_IDX_W-1:0] load_cnt;    // 0..2047
    op_pkg::opcode_t                 cmd_q;       // opcode held for view update

    // ------------------------------------------------------------------
    // sampled host inputs, one cycle in
    // ------------------------------------------------------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            op_valid_r <= 1'b0;
            op_mode_r  <= '0;
            in_valid_r <= 1'b0;
        end else begin
            op_valid_r <= i_op_valid;
            op_mode_r  <= i_op_mode;
            in_valid_r <= i_in_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        in_data_r <= i_in_data;
    end

    // next state and display kick-off
    always_comb begin
        state_next   = state;
        o_disp_start = 1'b0;
        case (state)
            S_RESET: state_next = S_START;
            S_START: state_next = S_READY;
            S_READY: state_next = S_WAIT;
            S_WAIT: begin
                if (op_valid_r) begin
                    case (op_mode_r)
                        op_pkg::OP_LOAD: state_next = S_LOAD;
                        op_pkg::OP_ORG_R, op_pkg::OP_ORG_L, op_pkg::OP_ORG_U,
                        op_pkg::OP_ORG_D, op_pkg::OP_SCALE_D, op_pkg::OP_SCALE_U: begin
                            state_next = S_VIEW;
                        end
                        op_pkg::OP_DISPLAY: begin
                            state_next   = S_DISP;
                            o_disp_start = 1'b1;
                        end
                        default: ;                // 8..15 dropped, keep waiting
                    endcase
                end
            end
            S_LOAD: begin
                if (o_wr_en && (load_cnt == image_pkg::PIX_IDX_W'(image_pkg::IMG_PIX - 1))) begin
                    state_next = S_READY;
                end
            end
            S_VIEW:  state_next = S_READY;        // view_regs updates this cycle
            S_DISP: begin
                if (i_disp_done) state_next = S_READY;
            end
            default: state_next = S_RESET;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state    <= S_RESET;
            cmd_q    <= op_pkg::OP_LOAD;
            load_cnt <= '0;
        end else begin
            state <= state_next;
            if (state == S_WAIT && op_valid_r) begin
                cmd_q <= op_pkg::opcode_t'(op_mode_r);
            end
            if (o_wr_en) begin
                load_cnt <= load_cnt + 1'b1;      // wraps to 0 after last pixel
            end
        end
    end

    assign o_op_ready       = (state == S_READY);
    assign o_in_ready       = (state == S_LOAD);  // level for the whole load
    assign o_wr_en          = o_in_ready && in_valid_r;
    assign o_wr_idx         = load_cnt;
    assign o_wr_data        = in_data_r;
    assign o_view_cmd_valid = (state == S_VIEW);
    assign o_view_cmd       = cmd_q;

endmodule

`default_nettype wire

// ==== rtl/display_streamer.sv ====
`timescale 1ns/1ns
`default_nettype none

module display_streamer (
    input  logic                               i_clk,
    input  logic                               i_rst_n,
    input  logic                               i_start,
    input  logic [image_pkg::COORD_W-1:0]      i_origin_x,
    input  logic [image_pkg::COORD_W-1:0]      i_origin_y,
    input  image_pkg::depth_t                  i_depth,
    input  logic [image_pkg::PIX_W-1:0]        i_rd_data,
    output logic                               o_rd_en,
    output logic [image_pkg::COORD_W-1:0]      o_rd_x,
    output logic [image_pkg::COORD_W-1:0]      o_rd_y,
    output logic [image_pkg::CHAN_W-1:0]       o_rd_c,
    output logic                               o_out_valid,
    output logic signed [image_pkg::OUT_W-1:0] o_out_data,
    output logic                               o_disp_done
);

    logic                         busy;
    logic [1:0]                   tile;        // 0 origin, 1 x+1, 2 y+1, 3 x+1,y+1
    logic [image_pkg::CHAN_W-1:0] chan;
    logic                         last_rd;
    logic                         rd_vld_q;    // stage 1, sram latency
    logic                         rd_last_q;

    assign o_rd_en = busy;
    assign o_rd_x  = i_origin_x + image_pkg::COORD_W'(tile[0]);
    assign o_rd_y  = i_origin_y + image_pkg::COORD_W'(tile[1]);
    assign o_rd_c  = chan;
    assign last_rd = busy && (tile == 2'd3) && (chan == image_pkg::depth_last_chan(i_depth));

    // ------------------------------------------------------------------
    // read issue, one per cycle, tile inner and channel outer
    // ------------------------------------------------------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            busy <= 1'b0;
            tile <= 2'd0;
            chan <= '0;
        end else if (i_start) begin
            busy <= 1'b1;
            tile <= 2'd0;
            chan <= '0;
        end else if (busy) begin
            tile <= tile + 2'd1;                      // wraps after the 4th pixel
            if (last_rd) begin
                busy <= 1'b0;
            end else if (tile == 2'd3) begin
                chan <= chan + 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------
    // output pipeline, sram stage then output register
    // ------------------------------------------------------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rd_vld_q    <= 1'b0;
            rd_last_q   <= 1'b0;
            o_out_valid <= 1'b0;
            o_disp_done <= 1'b0;
            o_out_data  <= '0;
        end else begin
            rd_vld_q    <= o_rd_en;
            rd_last_q   <= last_rd;
            o_out_valid <= rd_vld_q;
            o_disp_done <= rd_last_q;                 // rides with the last word
            if (rd_vld_q) begin
                o_out_data <= {{(image_pkg::OUT_W - image_pkg::PIX_W){1'b0}}, i_rd_data};
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/view_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

module view_regs (
    input  logic                          i_clk,
    input  logic                          i_rst_n,
    input  logic                          i_cmd_valid,   // one-cycle strobe
    input  op_pkg::opcode_t               i_cmd,
    output logic [image_pkg::COORD_W-1:0] o_origin_x,
    output logic [image_pkg::COORD_W-1:0] o_origin_y,
    output image_pkg::depth_t             o_depth
);

    localparam logic [image_pkg::COORD_W-1:0] ORG_MAX = image_pkg::COORD_W'(image_pkg::ORIGIN_MAX);

    // shifts and scales saturate, a command at a limit is a no-op
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_origin_x <= '0;
            o_origin_y <= '0;
            o_depth    <= image_pkg::DEPTH_32;           // full depth out of reset
        end else if (i_cmd_valid) begin
            case (i_cmd)
                op_pkg::OP_ORG_R: begin
                    if (o_origin_x < ORG_MAX) o_origin_x <= o_origin_x + 1'b1;
                end
                op_pkg::OP_ORG_L: begin
                    if (o_origin_x != '0) o_origin_x <= o_origin_x - 1'b1;
                end
                op_pkg::OP_ORG_U: begin
                    if (o_origin_y != '0) o_origin_y <= o_origin_y - 1'b1;   // up is y-1
                end
                op_pkg::OP_ORG_D: begin
                    if (o_origin_y < ORG_MAX) o_origin_y <= o_origin_y + 1'b1;
                end
                op_pkg::OP_SCALE_D: begin
                    if (o_depth != image_pkg::DEPTH_8) begin
                        o_depth <= image_pkg::depth_t'(o_depth - 2'd1);
                    end
                end
                op_pkg::OP_SCALE_U: begin
                    if (o_depth != image_pkg::DEPTH_32) begin
                        o_depth <= image_pkg::depth_t'(o_depth + 2'd1);
                    end
                end
                default: ;                               // load/display not ours
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/image_mem.sv ====
`timescale 1ns/1ns
`default_nettype none

module image_mem #(
    parameter int NUM_BANKS = 4
) (
    input  logic                            i_clk,
    input  logic                            i_wr_en,
    input  logic [image_pkg::PIX_IDX_W-1:0] i_wr_idx,
    input  logic [image_pkg::PIX_W-1:0]     i_wr_data,
    input  logic                            i_rd_en,
    input  logic [image_pkg::COORD_W-1:0]   i_rd_x,
    input  logic [image_pkg::COORD_W-1:0]   i_rd_y,
    input  logic [image_pkg::CHAN_W-1:0]    i_rd_c,
    output logic [image_pkg::PIX_W-1:0]     o_rd_data
);

    localparam int BANK_DEPTH = image_pkg::IMG_PIX / NUM_BANKS;
    localparam int ADDR_W     = $clog2(BANK_DEPTH);
    localparam int SEL_W      = (NUM_BANKS > 1) ? $clog2(NUM_BANKS) : 1;
    localparam int PLANE      = image_pkg::IMG_W * image_pkg::IMG_H;   // pixels per channel

    logic [image_pkg::CHAN_W-1:0] wr_c;
    logic [SEL_W-1:0]             wr_sel;
    logic [SEL_W-1:0]             rd_sel;
    logic [SEL_W-1:0]             sel;
    logic [SEL_W-1:0]             rd_sel_q;
    logic [ADDR_W-1:0]            wr_off;
    logic [ADDR_W-1:0]            rd_off;
    logic [ADDR_W-1:0]            addr;
    logic [image_pkg::PIX_W-1:0]  bank_q [NUM_BANKS];

    // ------------------------------------------------------------------
    // address mapping: bank = c mod N, offset = (c div N)*64 + y*8 + x
    // ------------------------------------------------------------------
    assign wr_c   = i_wr_idx[image_pkg::PIX_IDX_W-1 -: image_pkg::CHAN_W];   // channel on top
    assign wr_sel = SEL_W'(wr_c % NUM_BANKS);
    assign wr_off = ADDR_W'((wr_c / NUM_BANKS) * PLANE
                            + i_wr_idx[2*image_pkg::COORD_W-1:0]);            // y,x already packed

    assign rd_sel = SEL_W'(i_rd_c % NUM_BANKS);
    assign rd_off = ADDR_W'((i_rd_c / NUM_BANKS) * PLANE
                            + i_rd_y * image_pkg::IMG_W + i_rd_x);

    // load and display never run together
    assign sel  = i_wr_en ? wr_sel : rd_sel;
    assign addr = i_wr_en ? wr_off : rd_off;

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        sram_bank #(
            .ADDR_W(ADDR_W)
        ) u_bank (
            .i_clk (i_clk),
            .i_cen (!((i_wr_en || i_rd_en) && (sel == SEL_W'(b)))),   // only addressed bank
            .i_wen (!i_wr_en),
            .i_addr(addr),
            .i_d   (i_wr_data),
            .o_q   (bank_q[b])
        );
    end

    // bank number trails the read by a cycle, lines up with q
    always_ff @(posedge i_clk) begin
        if (i_rd_en) begin
            rd_sel_q <= rd_sel;
        end
    end

    assign o_rd_data = bank_q[rd_sel_q];

endmodule

`default_nettype wire

// ==== rtl/sram_bank.sv ====
`timescale 1ns/1ns
`default_nettype none

module sram_bank #(
    parameter int ADDR_W = 9
) (
    input  logic                        i_clk,
    input  logic                        i_cen,     // chip enable, active low
    input  logic                        i_wen,     // low writes, high reads
    input  logic [ADDR_W-1:0]           i_addr,
    input  logic [image_pkg::PIX_W-1:0] i_d,
    output logic [image_pkg::PIX_W-1:0] o_q
);

    logic [image_pkg::PIX_W-1:0] mem [2**ADDR_W];

    // single port, one access per edge
    always_ff @(posedge i_clk) begin
        if (!i_cen) begin
            if (!i_wen) begin
                mem[i_addr] <= i_d;
            end else begin
                o_q <= mem[i_addr];            // q holds until the next read
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/op_pkg.sv ====
`default_nettype none

package op_pkg;

    localparam int OP_W = 4;                   // width of i_op_mode

    // host opcodes, codes 8..15 are not handled by this core
    typedef enum logic [OP_W-1:0] {
        OP_LOAD    = 4'd0,                     // take 2048 pixels
        OP_ORG_R   = 4'd1,
        OP_ORG_L   = 4'd2,
        OP_ORG_U   = 4'd3,
        OP_ORG_D   = 4'd4,
        OP_SCALE_D = 4'd5,                     // fewer channels
        OP_SCALE_U = 4'd6,                     // more channels
        OP_DISPLAY = 4'd7                      // stream the window
    } opcode_t;

endpackage

`default_nettype wire

// ==== rtl/image_pkg.sv ====
`default_nettype none

package image_pkg;

    // ------------------------------------------------------------------
    // image geometry
    // ------------------------------------------------------------------
    localparam int IMG_W   = 8;
    localparam int IMG_H   = 8;
    localparam int IMG_C   = 32;
    localparam int IMG_PIX = IMG_W * IMG_H * IMG_C;    // 2048 pixels

    localparam int PIX_W     = 8;                      // unsigned pixel
    localparam int OUT_W     = 14;                     // signed output word
    localparam int COORD_W   = 3;                      // x or y
    localparam int CHAN_W    = 5;                      // channel index
    localparam int PIX_IDX_W = 11;                     // load index {c, y, x}

    // 2x2 window has to fit, so origin stops one short of the edge
    localparam int ORIGIN_MAX = IMG_W - 2;

    // displayed depth, declaration order is the scale order
    typedef enum logic [1:0] {
        DEPTH_8,
        DEPTH_16,
        DEPTH_32
    } depth_t;

    // last channel shown at a given depth
    function automatic logic [CHAN_W-1:0] depth_last_chan(input depth_t d);
        case (d)
            DEPTH_8:  return CHAN_W'(7);
            DEPTH_16: return CHAN_W'(15);
            default:  return CHAN_W'(IMG_C - 1);
        endcase
    endfunction

endpackage

`default_nettype wire
